// ==== common/smc_ahb_pkg.sv ====
//--------------------------------------------------------------------------
// Bus-side types for the static memory controller. Holds the AHB response
// code, transfer encodings and the request/response records passed
// between the AHB slave front end and the EMI sequencer.
//--------------------------------------------------------------------------

package smc_ahb_pkg;

  // AHB response, only the two codes an AHB-lite slave needs
  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01
  } smc_hresp_e;

  // htrans encodings that start a transfer
  parameter logic [1:0] HTRANS_NONSEQ = 2'b10;
  parameter logic [1:0] HTRANS_SEQ    = 2'b11;

  // hsize encodings below word size
  parameter logic [2:0] HSIZE_BYTE = 3'b000;
  parameter logic [2:0] HSIZE_HALF = 3'b001;

  //--------------------------------------------------------------------------
  // Slave to sequencer
  //--------------------------------------------------------------------------
  typedef struct packed {
    logic        write;  // 1 = write cycle
    logic [31:0] addr;   // Word aligned, low ADDR_BITS meaningful
    logic [3:0]  n_be;   // Byte lanes, active low
    logic [31:0] wdata;  // Write data, held through data phase
  } smc_req_t;

  //--------------------------------------------------------------------------
  // Sequencer to slave
  //--------------------------------------------------------------------------
  typedef struct packed {
    logic        done;   // One cycle, in hold phase
    logic [31:0] rdata;  // Captured on last strobe cycle
  } smc_rsp_t;

endpackage

// ==== common/smc_emi_pkg.sv ====
//--------------------------------------------------------------------------
// Memory-side types. Timing record from the register block to the
// sequencer, the register word views and the APB register map.
//--------------------------------------------------------------------------

package smc_emi_pkg;

  parameter int SMC_PADDR_W = 5;  // APB offset width

  // Register map
  parameter logic [SMC_PADDR_W-1:0] SMC_REG_TIMING = 5'h00;
  parameter logic [SMC_PADDR_W-1:0] SMC_REG_CTRL   = 5'h04;
  parameter logic [SMC_PADDR_W-1:0] SMC_REG_STATUS = 5'h08;

  parameter logic SMC_ENABLE_RST = 1'b1;  // Controller enabled out of reset

  // Extra strobe cycles per access type
  typedef struct packed {
    logic [3:0] wr_ws;  // Bits [7:4]
    logic [3:0] rd_ws;  // Bits [3:0]
  } smc_timing_t;

  typedef struct packed {
    logic [23:0] rsvd;
    smc_timing_t timing;
  } smc_timing_view_t;

  // Single flag in bit 0, enable in CTRL and busy in STATUS
  typedef struct packed {
    logic [30:0] rsvd;
    logic        bit0;
  } smc_flag_view_t;

  typedef union packed {
    logic [31:0]      raw;   // APB data word
    smc_timing_view_t tim;
    smc_flag_view_t   flag;
  } smc_cfg_word_u;

endpackage

// ==== rtl/ahb_slave/smc_ahb_slave.sv ====
//--------------------------------------------------------------------------
// AHB-lite slave front end. Registers the address phase, builds byte
// enables, range checks the address and either starts one memory cycle
// or answers with a two-cycle ERROR. Stalls hready until the sequencer
// reports done.
//--------------------------------------------------------------------------

module smc_ahb_slave #(
  parameter int ADDR_BITS = 16
) (
  input  logic                    hclk,
  input  logic                    rst,
  input  logic                    hsel,
  input  logic [31:0]             haddr,
  input  logic [1:0]              htrans,
  input  logic                    hwrite,
  input  logic [2:0]              hsize,
  input  logic [31:0]             hwdata,
  input  logic                    hready,      // Muxed bus ready
  input  logic                    enable,      // From config block
  input  smc_ahb_pkg::smc_rsp_t   rsp,
  output logic [31:0]             smc_hrdata,
  output logic                    smc_hready,
  output smc_ahb_pkg::smc_hresp_e smc_hresp,
  output logic                    smc_valid,
  output smc_ahb_pkg::smc_req_t   req,
  output logic                    req_start
);

  import smc_ahb_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,  // Ready, OKAY
    ST_WAIT,  // Memory cycle running
    ST_ERR1,  // First error cycle, hready low
    ST_ERR2   // Second error cycle, hready high
  } state_e;

  state_e      state_q;
  logic        accept;
  logic        addr_ok;
  logic [3:0]  n_be;
  logic        start_q;
  logic        write_q;
  logic [31:0] addr_q;
  logic [3:0]  n_be_q;
  logic [31:0] hrdata_q;

  assign accept = hsel && hready && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);
  assign addr_ok = enable && (haddr[31:ADDR_BITS] == '0);  // In range and enabled

  // Little endian lane decode
  always_comb begin
    case (hsize)
      HSIZE_BYTE: n_be = ~(4'b0001 << haddr[1:0]);
      HSIZE_HALF: n_be = ~(4'b0011 << {haddr[1], 1'b0});
      default:    n_be = 4'b0000;  // Word
    endcase
  end

  //--------------------------------------------------------------------------
  // Data phase control
  //--------------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0;  // One cycle pulse
      case (state_q)
        ST_IDLE, ST_ERR2: begin
          state_q <= ST_IDLE;
          if (accept && addr_ok) begin
            state_q <= ST_WAIT;
            start_q <= 1'b1;
          end else if (accept) begin
            state_q <= ST_ERR1;  // No memory cycle
          end
        end
        ST_WAIT: begin
          if (rsp.done) begin
            state_q <= ST_IDLE;  // hready high after hold
          end
        end
        ST_ERR1: state_q <= ST_ERR2;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Address phase capture
  always_ff @(posedge hclk) begin
    if (accept && addr_ok) begin
      write_q <= hwrite;
      addr_q  <= {haddr[31:2], 2'b00};
      n_be_q  <= n_be;
    end
    if (rsp.done && !write_q) begin
      hrdata_q <= rsp.rdata;  // Presented in completing cycle
    end
  end

  assign req_start  = start_q;
  assign smc_valid  = start_q;    // Valid address acknowledged
  assign smc_hready = (state_q == ST_IDLE) || (state_q == ST_ERR2);
  assign smc_hresp  = (state_q == ST_ERR1 || state_q == ST_ERR2) ? ERROR : OKAY;
  assign smc_hrdata = hrdata_q;

  assign req.write = write_q;
  assign req.addr  = addr_q;
  assign req.n_be  = n_be_q;
  assign req.wdata = hwdata;      // Master holds hwdata while hready low

endmodule

// ==== rtl/apb_cfg/smc_apb_cfg.sv ====
//--------------------------------------------------------------------------
// APB register block. Holds read/write wait states and the enable bit,
// reports busy in a read-only status word. Zero wait states, prdata is
// combinational in the access phase.
//--------------------------------------------------------------------------

module smc_apb_cfg (
  input  logic                                hclk,
  input  logic                                rst,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [smc_emi_pkg::SMC_PADDR_W-1:0] paddr,
  input  logic [31:0]                         pwdata,
  input  logic                                busy,     // Live from sequencer
  output logic [31:0]                         prdata,
  output smc_emi_pkg::smc_timing_t            timing,
  output logic                                enable
);

  import smc_emi_pkg::*;

  smc_cfg_word_u wr_word;
  smc_cfg_word_u rd_word;
  smc_timing_t   timing_q;
  logic          enable_q;
  logic          wr_en;

  assign wr_word.raw = pwdata;
  assign wr_en = psel && penable && pwrite;  // Access phase write

  //--------------------------------------------------------------------------
  // Register writes
  //--------------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      timing_q <= '0;              // No extra wait states
      enable_q <= SMC_ENABLE_RST;
    end else if (wr_en) begin
      case (paddr)
        SMC_REG_TIMING: timing_q <= wr_word.tim.timing;
        SMC_REG_CTRL:   enable_q <= wr_word.flag.bit0;
        default:        ;           // Status and holes ignore writes
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // Read mux
  //--------------------------------------------------------------------------
  always_comb begin
    rd_word.raw = '0;  // Unmapped reads zero
    case (paddr)
      SMC_REG_TIMING: rd_word.tim.timing = timing_q;
      SMC_REG_CTRL:   rd_word.flag.bit0  = enable_q;
      SMC_REG_STATUS: rd_word.flag.bit0  = busy;
      default:        rd_word.raw        = '0;
    endcase
  end

  // Drive bus only on a read select
  assign prdata = (psel && !pwrite) ? rd_word.raw : 32'h0;

  assign timing = timing_q;
  assign enable = enable_q;

endmodule

// ==== rtl/emi_ctrl/smc_emi_ctrl.sv ====
//--------------------------------------------------------------------------
// External memory sequencer for one asynchronous SRAM-style device.
// Setup phase coincides with req_start, then 1 + ws strobe cycles and one
// hold cycle. Wait states are snapshot at req_start, so timing writes
// during an access apply to the next one.
//--------------------------------------------------------------------------

module smc_emi_ctrl #(
  parameter int ADDR_BITS = 16
) (
  input  logic                     hclk,
  input  logic                     rst,
  input  smc_ahb_pkg::smc_req_t    req,
  input  logic                     req_start,
  input  smc_emi_pkg::smc_timing_t timing,
  input  logic [31:0]              data_smc,      // Read data from device
  output smc_ahb_pkg::smc_rsp_t    rsp,
  output logic                     busy,
  output logic [ADDR_BITS-1:0]     smc_addr,
  output logic [31:0]              smc_data,      // Write data to device
  output logic [3:0]               smc_n_be,
  output logic                     smc_n_cs,
  output logic [3:0]               smc_n_we,      // Per-byte write strobes
  output logic                     smc_n_wr,
  output logic                     smc_n_rd,
  output logic                     smc_n_ext_oe   // Write data driver enable
);

  typedef enum logic [1:0] {
    EMI_IDLE,
    EMI_STROBE,
    EMI_HOLD
  } emi_state_e;

  emi_state_e  state_q;
  logic [3:0]  ws_cnt_q;     // Remaining extra strobe cycles
  logic [3:0]  ws_sel;
  logic [31:0] rdata_q;
  logic        setup;
  logic        strobe;
  logic        hold;
  logic        active;
  logic        last_strobe;

  // Wait states for this access type
  assign ws_sel = req.write ? timing.wr_ws : timing.rd_ws;

  assign setup       = (state_q == EMI_IDLE) && req_start;
  assign strobe      = (state_q == EMI_STROBE);
  assign hold        = (state_q == EMI_HOLD);
  assign active      = setup || strobe || hold;  // Chip select window
  assign last_strobe = strobe && (ws_cnt_q == 4'd0);

  //--------------------------------------------------------------------------
  // Phase sequencing
  //--------------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      state_q  <= EMI_IDLE;
      ws_cnt_q <= 4'd0;
    end else begin
      case (state_q)
        EMI_IDLE: begin
          if (req_start) begin
            state_q  <= EMI_STROBE;
            ws_cnt_q <= ws_sel;  // Snapshot
          end
        end
        EMI_STROBE: begin
          if (ws_cnt_q == 4'd0) begin
            state_q <= EMI_HOLD;
          end else begin
            ws_cnt_q <= ws_cnt_q - 4'd1;
          end
        end
        EMI_HOLD: state_q <= EMI_IDLE;
        default:  state_q <= EMI_IDLE;
      endcase
    end
  end

  // Sample device at end of strobe
  always_ff @(posedge hclk) begin
    if (last_strobe && !req.write) begin
      rdata_q <= data_smc;
    end
  end

  //--------------------------------------------------------------------------
  // Device pins
  //--------------------------------------------------------------------------
  assign smc_addr     = req.addr[ADDR_BITS-1:0];
  assign smc_data     = req.wdata;
  assign smc_n_cs     = !active;
  assign smc_n_be     = active ? req.n_be : 4'hf;
  assign smc_n_rd     = !(strobe && !req.write);
  assign smc_n_wr     = !(strobe && req.write);
  assign smc_n_we     = (strobe && req.write) ? req.n_be : 4'hf;  // Lane strobes
  assign smc_n_ext_oe = !(active && req.write);  // Drive bus setup to hold

  assign rsp.done  = hold;
  assign rsp.rdata = rdata_q;
  assign busy      = active;

endmodule

// ==== rtl/smc_veneer.sv ====
//--------------------------------------------------------------------------
// Static memory controller top. Connects the AHB slave front end, the APB
// register block and the EMI sequencer, and sets the memory address width.
//--------------------------------------------------------------------------

module smc_veneer #(
  parameter int ADDR_BITS = 16  // External byte address width
) (
  input  logic                                hclk,
  input  logic                                rst,
  // AHB-lite slave
  input  logic                                hsel,
  input  logic [31:0]                         haddr,
  input  logic [1:0]                          htrans,
  input  logic                                hwrite,
  input  logic [2:0]                          hsize,
  input  logic [31:0]                         hwdata,
  input  logic                                hready,
  output logic [31:0]                         smc_hrdata,
  output logic                                smc_hready,
  output logic [1:0]                          smc_hresp,
  output logic                                smc_valid,
  // APB configuration
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [smc_emi_pkg::SMC_PADDR_W-1:0] paddr,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata,
  // External memory
  output logic [ADDR_BITS-1:0]                smc_addr,
  output logic [31:0]                         smc_data,
  input  logic [31:0]                         data_smc,
  output logic [3:0]                          smc_n_be,
  output logic                                smc_n_cs,
  output logic [3:0]                          smc_n_we,
  output logic                                smc_n_wr,
  output logic                                smc_n_rd,
  output logic                                smc_n_ext_oe,
  output logic                                smc_busy
);

  import smc_ahb_pkg::*;
  import smc_emi_pkg::*;

  smc_req_t    req;
  smc_rsp_t    rsp;
  logic        req_start;
  smc_timing_t timing;
  logic        enable;

  smc_ahb_slave #(
    .ADDR_BITS (ADDR_BITS)
  ) i_ahb_slave (
    .hclk       (hclk),
    .rst        (rst),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hsize      (hsize),
    .hwdata     (hwdata),
    .hready     (hready),
    .enable     (enable),
    .rsp        (rsp),
    .smc_hrdata (smc_hrdata),
    .smc_hready (smc_hready),
    .smc_hresp  (smc_hresp),
    .smc_valid  (smc_valid),
    .req        (req),
    .req_start  (req_start)
  );

  smc_apb_cfg i_apb_cfg (
    .hclk    (hclk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .busy    (smc_busy),
    .prdata  (prdata),
    .timing  (timing),
    .enable  (enable)
  );

  smc_emi_ctrl #(
    .ADDR_BITS (ADDR_BITS)
  ) i_emi_ctrl (
    .hclk         (hclk),
    .rst          (rst),
    .req          (req),
    .req_start    (req_start),
    .timing       (timing),
    .data_smc     (data_smc),
    .rsp          (rsp),
    .busy         (smc_busy),
    .smc_addr     (smc_addr),
    .smc_data     (smc_data),
    .smc_n_be     (smc_n_be),
    .smc_n_cs     (smc_n_cs),
    .smc_n_we     (smc_n_we),
    .smc_n_wr     (smc_n_wr),
    .smc_n_rd     (smc_n_rd),
    .smc_n_ext_oe (smc_n_ext_oe)
  );

endmodule

// ==== verification/smc_veneer_properties.sv ====
//--------------------------------------------------------------------------
// Concurrent checks on the external memory pins, bound into the EMI
// sequencer by the testbench. Checks the chip select width against the
// wait states, strobe exclusivity and strobes inside chip select.
//--------------------------------------------------------------------------

module smc_veneer_properties (
  input logic                     hclk,
  input logic                     rst,
  input smc_ahb_pkg::smc_req_t    req,
  input logic                     req_start,
  input smc_emi_pkg::smc_timing_t timing,
  input logic                     smc_n_cs,
  input logic [3:0]               smc_n_we,
  input logic                     smc_n_wr,
  input logic                     smc_n_rd
);

  logic       cs_q;      // n_cs one cycle back
  logic [4:0] cs_len_q;  // Low cycles so far
  logic [4:0] cs_exp_q;  // ws + 3 of the running access

  always_ff @(posedge hclk) begin
    if (rst) begin
      cs_q     <= 1'b1;
      cs_len_q <= '0;
      cs_exp_q <= '0;
    end else begin
      cs_q     <= smc_n_cs;
      cs_len_q <= smc_n_cs ? 5'd0 : cs_len_q + 5'd1;
      if (req_start) begin
        cs_exp_q <= (req.write ? timing.wr_ws : timing.rd_ws) + 5'd3;  // Setup snapshot
      end
    end
  end

  // Checked in the first cycle after chip select rises
  a_cs_width : assert property (@(posedge hclk) disable iff (rst)
    (smc_n_cs && !cs_q) |-> (cs_len_q == cs_exp_q))
    else $error("chip select low for %0d cycles, expected %0d", cs_len_q, cs_exp_q);

  a_rd_wr_excl : assert property (@(posedge hclk) disable iff (rst)
    !(!smc_n_rd && !smc_n_wr))
    else $error("read and write strobes low together");

  a_strobe_in_cs : assert property (@(posedge hclk) disable iff (rst)
    (!smc_n_rd || !smc_n_wr || smc_n_we != 4'hf) |-> !smc_n_cs)
    else $error("strobe low outside chip select");

endmodule

// ==== verification/tb_smc_veneer.sv ====
//--------------------------------------------------------------------------
// Testbench for the static memory controller. Drives AHB and APB traffic,
// models a 4 KB SRAM on the EMI pins and compares every data phase with
// a shadow memory reference. Stops on a cycle limit.
//--------------------------------------------------------------------------

module tb_smc_veneer;

  import smc_ahb_pkg::*;
  import smc_emi_pkg::*;

  localparam int ADDR_BITS  = 16;
  localparam int MEM_BYTES  = 4096;                       // SRAM model size
  localparam int N_XFER     = 80;                         // Upper bound on AHB transfers
  localparam int MAX_CYCLES = N_XFER * (15 + 4 + 2) + 1000;  // Worst phase plus APB margin
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  typedef struct packed {
    logic [1:0]  resp;
    logic        chk_data;  // Read with OKAY
    logic [31:0] rdata;
    logic [4:0]  low;       // hready low cycles
  } exp_t;

  logic hclk, rst, hsel, hwrite, hready, smc_hready, smc_valid;
  logic [31:0] haddr, hwdata, smc_hrdata, pwdata, prdata, smc_data, data_smc;
  logic [1:0] htrans, smc_hresp;
  logic [2:0] hsize;
  logic psel, penable, pwrite;
  logic [SMC_PADDR_W-1:0] paddr;
  logic [ADDR_BITS-1:0] smc_addr;
  logic [3:0] smc_n_be, smc_n_we;
  logic smc_n_cs, smc_n_wr, smc_n_rd, smc_n_ext_oe, smc_busy;

  logic [7:0] sram [MEM_BYTES];
  logic [7:0] shadow [MEM_BYTES];   // Reference copy
  logic [11:0] sram_base;
  exp_t  exp_q[$];
  string name_q[$];
  int errors, checks, cycles, low_cnt, valid_cnt;
  logic in_phase;
  logic cfg_en;                      // Register model
  logic [3:0] cfg_rd_ws, cfg_wr_ws;

  smc_veneer #(.ADDR_BITS(ADDR_BITS)) u_smc_veneer (.*);

  bind smc_emi_ctrl smc_veneer_properties u_props (
    .hclk(hclk), .rst(rst), .req(req), .req_start(req_start), .timing(timing),
    .smc_n_cs(smc_n_cs), .smc_n_we(smc_n_we), .smc_n_wr(smc_n_wr), .smc_n_rd(smc_n_rd)
  );

  always #50 hclk = ~hclk;

  always @(posedge hclk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run exceeded %0d cycles without finishing", MAX_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  //--------------------------------------------------------------------------
  // SRAM model, word wide with byte write lanes
  //--------------------------------------------------------------------------
  assign sram_base = {smc_addr[11:2], 2'b00};

  // Disabled lanes read back as zero
  always_comb begin
    data_smc = 32'h0;
    for (int i = 0; i < 4; i++) begin
      if (!smc_n_cs && !smc_n_rd && !smc_n_be[i]) begin
        data_smc[8*i +: 8] = sram[sram_base + 12'(i)];
      end
    end
  end

  always @(posedge hclk) begin
    if (!smc_n_cs && !smc_n_wr) begin
      for (int i = 0; i < 4; i++) begin
        // Lane enabled and write driver on
        if (!smc_n_we[i] && !smc_n_be[i] && !smc_n_ext_oe) begin
          sram[sram_base + 12'(i)] <= smc_data[8*i +: 8];
        end
      end
    end
  end

  function automatic logic [7:0] fill_byte(int a);
    return a[7:0] ^ {a[11:8], a[11:8]};  // Uses all 12 address bits
  endfunction

  function automatic logic [3:0] lane_mask(logic [2:0] size, logic [1:0] a);
    logic [3:0] m;
    for (int i = 0; i < 4; i++) begin
      case (size)
        HSIZE_BYTE: m[i] = (i == a);
        HSIZE_HALF: m[i] = ((i / 2) == a[1]);
        default:    m[i] = 1'b1;
      endcase
    end
    return m;
  endfunction

  // Expected response of one transfer; OKAY writes update the shadow
  function automatic exp_t ref_expect(logic write, logic [31:0] addr, logic [2:0] size,
                                      logic [31:0] wdata);
    exp_t e;
    logic [3:0] m;
    logic [11:0] b;
    m = lane_mask(size, addr[1:0]);
    b = {addr[11:2], 2'b00};
    e.resp = (cfg_en && addr < (32'd1 << ADDR_BITS)) ? OKAY : ERROR;
    e.chk_data = !write && (e.resp == OKAY);
    e.rdata = {shadow[b + 12'd3], shadow[b + 12'd2], shadow[b + 12'd1], shadow[b]};
    e.low = (e.resp == ERROR) ? 5'd1 : 5'(write ? cfg_wr_ws : cfg_rd_ws) + 5'd3;
    for (int i = 0; i < 4; i++) begin
      if (write && e.resp == OKAY && m[i]) shadow[b + 12'(i)] = wdata[8*i +: 8];
    end
    return e;
  endfunction

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  //--------------------------------------------------------------------------
  // Bus drivers
  //--------------------------------------------------------------------------
  task automatic ahb_xfer(string name, logic write, logic [31:0] addr, logic [2:0] size,
                          logic [31:0] wdata);
    exp_q.push_back(ref_expect(write, addr, size, wdata));
    name_q.push_back(name);
    @(posedge hclk);
    hsel   <= 1'b1;
    htrans <= HTRANS_NONSEQ;
    haddr  <= addr;
    hwrite <= write;
    hsize  <= size;
    @(posedge hclk);
    hsel   <= 1'b0;
    htrans <= 2'b00;  // IDLE during data phase
    hwdata <= wdata;
    @(negedge hclk);
    while (!smc_hready) @(negedge hclk);
  endtask

  task automatic apb_write(logic [SMC_PADDR_W-1:0] addr, logic [31:0] data);
    @(posedge hclk);
    psel   <= 1'b1;
    pwrite <= 1'b1;
    paddr  <= addr;
    pwdata <= data;
    @(posedge hclk);
    penable <= 1'b1;
    @(posedge hclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    if (addr == SMC_REG_TIMING) begin
      cfg_rd_ws = data[3:0];
      cfg_wr_ws = data[7:4];
    end
    if (addr == SMC_REG_CTRL) cfg_en = data[0];
  endtask

  task automatic apb_check(string name, logic [SMC_PADDR_W-1:0] addr, logic [31:0] exp);
    @(posedge hclk);
    psel  <= 1'b1;
    paddr <= addr;
    @(posedge hclk);
    penable <= 1'b1;
    @(negedge hclk);
    check_val(name, exp, prdata);  // Access phase, zero wait
    @(posedge hclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // Compare process, one check set per completed data phase
  always @(negedge hclk) begin
    exp_t  e;
    string n;
    if (in_phase && smc_valid) valid_cnt++;  // One per memory cycle issued
    if (in_phase && !smc_hready) low_cnt++;
    else if (in_phase) begin
      in_phase = 1'b0;
      assert (exp_q.size() != 0) else begin
        $display("A data phase completed with no transfer issued");
        errors++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        n = name_q.pop_front();
        check_val({n, " hresp"}, 32'(e.resp), 32'(smc_hresp));
        check_val({n, " hready low cycles"}, 32'(e.low), low_cnt);
        check_val({n, " smc_valid cycles"}, (e.resp == OKAY) ? 32'd1 : 32'd0, valid_cnt);
        if (e.chk_data) check_val({n, " hrdata"}, e.rdata, smc_hrdata);
      end
    end
    if (!rst && hsel && hready && htrans[1] && smc_hready) begin
      in_phase  = 1'b1;  // Accepted at next edge
      low_cnt   = 0;
      valid_cnt = 0;
    end
  end

  //--------------------------------------------------------------------------
  // Tests
  //--------------------------------------------------------------------------
  initial begin
    logic [31:0] waddr [16];
    logic [31:0] a;
    void'($urandom(32'hb47f_980c));
    {hclk, hsel, hwrite, psel, penable, pwrite, in_phase} = '0;
    {haddr, hwdata, pwdata, htrans, hsize, paddr} = '0;
    {errors, checks, cycles, low_cnt, valid_cnt} = '0;
    rst = 1'b1;
    hready = 1'b1;  // Single slave bus
    cfg_en = 1'b1;
    {cfg_rd_ws, cfg_wr_ws} = '0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      sram[i]   = fill_byte(i);
      shadow[i] = fill_byte(i);
    end
    repeat (8) @(posedge hclk);
    rst <= 1'b0;
    @(negedge hclk);
    check_val("reset outputs", {4'hf, 4'hf, 4'hf, 4'b1100},
              {smc_n_cs, smc_n_rd, smc_n_wr, smc_n_ext_oe, smc_n_we, smc_n_be,
               smc_hready, smc_hresp == OKAY, smc_valid, smc_busy});

    apb_write(SMC_REG_TIMING, 32'hcafe_0063);  // Reserved bits dropped
    apb_check("timing reg", SMC_REG_TIMING, 32'h0000_0063);
    apb_write(SMC_REG_CTRL, 32'h0000_0003);
    apb_check("ctrl reg", SMC_REG_CTRL, 32'h0000_0001);
    apb_check("status idle", SMC_REG_STATUS, 32'h0);

    for (int i = 0; i < 16; i++) begin
      waddr[i] = $urandom & 32'h0000_0ffc;
      ahb_xfer("word write", 1'b1, waddr[i], HSIZE_WORD, $urandom);
    end
    for (int i = 0; i < 16; i++) ahb_xfer("word read", 1'b0, waddr[i], HSIZE_WORD, 0);
    for (int i = 0; i < 8; i++) begin
      ahb_xfer("random read", 1'b0, $urandom & 32'h0000_0ffc, HSIZE_WORD, 0);
    end

    for (int i = 0; i < 4; i++) begin
      a = $urandom & 32'h0000_0ffc;
      ahb_xfer("byte write", 1'b1, a | ($urandom & 3), HSIZE_BYTE, $urandom);
      ahb_xfer("half write", 1'b1, a | ($urandom & 2), HSIZE_HALF, $urandom);
      ahb_xfer("lane merge read", 1'b0, a, HSIZE_WORD, 0);
    end

    for (int i = 0; i < 4; i++) begin
      apb_write(SMC_REG_TIMING, $urandom & 32'hff);
      a = $urandom & 32'h0000_0ffc;
      ahb_xfer("wait state write", 1'b1, a, HSIZE_WORD, $urandom);
      ahb_xfer("wait state read", 1'b0, a, HSIZE_WORD, 0);
    end

    // Out of range write aliases onto 0x040 in the SRAM model
    apb_write(SMC_REG_TIMING, 32'h11);
    ahb_xfer("out of range write", 1'b1, 32'h0001_0040, HSIZE_WORD, 32'h1234_5678);
    ahb_xfer("alias read", 1'b0, 32'h0000_0040, HSIZE_WORD, 0);
    ahb_xfer("out of range read", 1'b0, 32'h8000_0000, HSIZE_WORD, 0);
    apb_write(SMC_REG_CTRL, 32'h0);
    ahb_xfer("disabled write", 1'b1, 32'h0000_0040, HSIZE_WORD, 32'h8765_4321);
    ahb_xfer("disabled read", 1'b0, 32'h0000_0040, HSIZE_WORD, 0);
    apb_write(SMC_REG_CTRL, 32'h1);
    ahb_xfer("re-enabled read", 1'b0, 32'h0000_0040, HSIZE_WORD, 0);

    repeat (4) @(posedge hclk);
    assert (exp_q.size() == 0) else begin
      $display("%0d transfers issued but never completed", exp_q.size());
      errors++;
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== smc_veneer.f ====
common/smc_ahb_pkg.sv
common/smc_emi_pkg.sv
rtl/ahb_slave/smc_ahb_slave.sv
rtl/apb_cfg/smc_apb_cfg.sv
rtl/emi_ctrl/smc_emi_ctrl.sv
rtl/smc_veneer.sv
verification/smc_veneer_properties.sv
verification/tb_smc_veneer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_smc_veneer \
  -f smc_veneer.f -o tb_smc_veneer || { echo "Build failed"; exit 1; }

out=$(./obj_dir/tb_smc_veneer)
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
